// File: Bender.yml
package:
  name: io_switch

sources:
  - include_dirs:
      - design
    files:
      - design/ioSwitchPkg.sv
      - design/addrDecoder.sv
      - design/reqFifo.sv
      - design/ioDispatcher.sv
      - design/ioSwitch.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/ioSwitchTb.sv

// File: design/addrDecoder.sv
`include "ioSwitch_settings.svh"

module addrDecoder (
  input  logic                         clk_i,
  input  logic                         rst_i,
  // host request
  input  logic                         reqValid_i,
  output logic                         reqReady_o,
  input  logic [`IO_ADDR_WIDTH-1:0]    reqAddr_i,
  input  logic                         reqWrite_i,
  input  logic [`IO_DATA_WIDTH-1:0]    reqData_i,
  input  logic [`IO_SOURCE_WIDTH-1:0]  reqSource_i,
  // decoded item towards the FIFO
  output logic                         itemValid_o,
  output ioSwitchPkg::ioReq_t          item_o,
  input  logic                         fifoFull_i
);

  import ioSwitchPkg::*;

  localparam int NumWin = 5;

  localparam logic [`IO_ADDR_WIDTH-1:0] WinBase [NumWin] = '{
    `CLINT_BASE, `PLIC_BASE, `UART_BASE, `SDHCI_BASE, `DVI_BASE
  };
  localparam logic [`IO_ADDR_WIDTH-1:0] WinMask [NumWin] = '{
    `CLINT_MASK, `PLIC_MASK, `UART_MASK, `SDHCI_MASK, `DVI_MASK
  };
  localparam ioTarget_e WinTarget [NumWin] = '{
    TgtClint, TgtPlic, TgtUart, TgtSdhci, TgtDvi
  };

  ioTarget_e                  decTarget;
  logic [`IO_ADDR_WIDTH-1:0]  decOffset;
  logic                       accept;

  //////////////////////////////////////////////////
  // window match
  //////////////////////////////////////////////////

  // windows never overlap, so at most one hits
  always_comb begin
    decTarget = TgtError;
    decOffset = '0;
    for (int i = 0; i < NumWin; i++) begin
      if ((reqAddr_i & ~WinMask[i]) == WinBase[i]) begin
        decTarget = WinTarget[i];
        decOffset = reqAddr_i & WinMask[i];
      end
    end
  end

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////

  // register free, or draining into the FIFO this cycle
  assign reqReady_o = !itemValid_o || !fifoFull_i;
  assign accept     = reqValid_i && reqReady_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      itemValid_o <= 1'b0;
    end else if (accept) begin
      itemValid_o <= 1'b1;
    end else if (!fifoFull_i) begin
      itemValid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      item_o.target <= decTarget;
      item_o.offset <= decOffset;
      item_o.write  <= reqWrite_i;
      item_o.data   <= reqData_i;
      item_o.source <= reqSource_i;
    end
  end

  // a blocked item must not change before the FIFO takes it
  assert property (@(posedge clk_i) disable iff (rst_i)
    itemValid_o && fifoFull_i |=> itemValid_o && $stable(item_o));

endmodule

// File: design/ioDispatcher.sv
`include "ioSwitch_settings.svh"

module ioDispatcher (
  input  logic                         clk_i,
  input  logic                         rst_i,
  // FIFO head
  input  logic                         fifoEmpty_i,
  input  ioSwitchPkg::ioReq_t          head_i,
  output logic                         pop_o,
  // device port
  output logic                         devValid_o,
  output ioSwitchPkg::ioTarget_e       devTarget_o,
  output logic [`IO_ADDR_WIDTH-1:0]    devOffset_o,
  output logic                         devWrite_o,
  output logic [`IO_DATA_WIDTH-1:0]    devData_o,
  output logic [`IO_SOURCE_WIDTH-1:0]  devSource_o,
  input  logic                         devReady_i,
  // error sink
  output logic                         errValid_o,
  output logic [`IO_SOURCE_WIDTH-1:0]  errSource_o
);

  import ioSwitchPkg::*;

  logic slotFree;
  logic headIsErr;
  logic loadDev;
  logic loadErr;

  //////////////////////////////////////////////////
  // pop control
  //////////////////////////////////////////////////

  // output register empty, or handing its item over now
  assign slotFree  = !devValid_o || devReady_i;

  // error items wait here too, so order is kept
  assign pop_o     = !fifoEmpty_i && slotFree;
  assign headIsErr = head_i.target == TgtError;
  assign loadDev   = pop_o && !headIsErr;
  assign loadErr   = pop_o && headIsErr;

  //////////////////////////////////////////////////
  // device output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      devValid_o <= 1'b0;
    end else if (loadDev) begin
      devValid_o <= 1'b1;
    end else if (devReady_i) begin
      devValid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (loadDev) begin
      devTarget_o <= head_i.target;
      devOffset_o <= head_i.offset;
      devWrite_o  <= head_i.write;
      devData_o   <= head_i.data;
      devSource_o <= head_i.source;
    end
  end

  //////////////////////////////////////////////////
  // error sink
  //////////////////////////////////////////////////

  // one pulse per miss, no handshake back
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      errValid_o <= 1'b0;
    end else begin
      errValid_o <= loadErr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (loadErr) begin
      errSource_o <= head_i.source;
    end
  end

  // stalled transfer holds until the device takes it
  assert property (@(posedge clk_i) disable iff (rst_i)
    devValid_o && !devReady_i |=> devValid_o
      && $stable(devTarget_o) && $stable(devOffset_o) && $stable(devWrite_o)
      && $stable(devData_o) && $stable(devSource_o));

endmodule

// File: design/ioSwitch.sv
`include "ioSwitch_settings.svh"

module ioSwitch (
  input  logic                         clk_i,
  input  logic                         rst_i,
  // host side
  input  logic                         reqValid_i,
  output logic                         reqReady_o,
  input  logic [`IO_ADDR_WIDTH-1:0]    reqAddr_i,
  input  logic                         reqWrite_i,
  input  logic [`IO_DATA_WIDTH-1:0]    reqData_i,
  input  logic [`IO_SOURCE_WIDTH-1:0]  reqSource_i,
  // device side
  output logic                         devValid_o,
  output ioSwitchPkg::ioTarget_e       devTarget_o,
  output logic [`IO_ADDR_WIDTH-1:0]    devOffset_o,
  output logic                         devWrite_o,
  output logic [`IO_DATA_WIDTH-1:0]    devData_o,
  output logic [`IO_SOURCE_WIDTH-1:0]  devSource_o,
  input  logic                         devReady_i,
  // error responses
  output logic                         errValid_o,
  output logic [`IO_SOURCE_WIDTH-1:0]  errSource_o
);

  // decoder to FIFO
  logic                 itemValid;
  ioSwitchPkg::ioReq_t  item;
  logic                 fifoFull;

  // FIFO to dispatcher
  logic                 fifoEmpty;
  ioSwitchPkg::ioReq_t  head;
  logic                 pop;

  addrDecoder decoder0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .reqValid_i  (reqValid_i),
    .reqReady_o  (reqReady_o),
    .reqAddr_i   (reqAddr_i),
    .reqWrite_i  (reqWrite_i),
    .reqData_i   (reqData_i),
    .reqSource_i (reqSource_i),
    .itemValid_o (itemValid),
    .item_o      (item),
    .fifoFull_i  (fifoFull)
  );

  reqFifo #(
    .Depth (`REQ_FIFO_DEPTH)
  ) fifo0 (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .push_i     (itemValid),
    .pushItem_i (item),
    .full_o     (fifoFull),
    .pop_i      (pop),
    .popItem_o  (head),
    .empty_o    (fifoEmpty)
  );

  ioDispatcher dispatcher0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .fifoEmpty_i (fifoEmpty),
    .head_i      (head),
    .pop_o       (pop),
    .devValid_o  (devValid_o),
    .devTarget_o (devTarget_o),
    .devOffset_o (devOffset_o),
    .devWrite_o  (devWrite_o),
    .devData_o   (devData_o),
    .devSource_o (devSource_o),
    .devReady_i  (devReady_i),
    .errValid_o  (errValid_o),
    .errSource_o (errSource_o)
  );

endmodule

// File: design/ioSwitchPkg.sv
`include "ioSwitch_settings.svh"

package ioSwitchPkg;

  //////////////////////////////////////////////////
  // device targets
  //////////////////////////////////////////////////

  // one code per IO window, plus the error sink
  typedef enum logic [2:0] {
    TgtClint,
    TgtPlic,
    TgtUart,
    TgtSdhci,
    TgtDvi,
    TgtError
  } ioTarget_e;

  //////////////////////////////////////////////////
  // decoded request
  //////////////////////////////////////////////////

  // what the decoder hands to the FIFO and the dispatcher
  typedef struct packed {
    // selected device, or the error sink on a miss
    ioTarget_e                    target;
    // address relative to the window base, zero on a miss
    logic [`IO_ADDR_WIDTH-1:0]    offset;
    // 1 for a write, 0 for a read
    logic                         write;
    logic [`IO_DATA_WIDTH-1:0]    data;
    // host source ID, returned unchanged
    logic [`IO_SOURCE_WIDTH-1:0]  source;
  } ioReq_t;

endpackage

// File: design/ioSwitch_settings.svh
`ifndef IO_SWITCH_SETTINGS_SVH
`define IO_SWITCH_SETTINGS_SVH

//////////////////////////////////////////////////
// request field widths
//////////////////////////////////////////////////

`define IO_ADDR_WIDTH   38
`define IO_DATA_WIDTH   64
`define IO_SOURCE_WIDTH 5

// entries in the decoded request FIFO
`define REQ_FIFO_DEPTH  4

//////////////////////////////////////////////////
// IO address map, base and mask per window
//////////////////////////////////////////////////

`define CLINT_BASE 'h11400000
`define CLINT_MASK 'h0000FFFF

`define PLIC_BASE  'h11000000
`define PLIC_MASK  'h003FFFFF

`define UART_BASE  'h10000000
`define UART_MASK  'h00001FFF

`define SDHCI_BASE 'h10010000
`define SDHCI_MASK 'h00000FFF

`define DVI_BASE   'h10020000
`define DVI_MASK   'h00000FFF

`endif

// File: design/reqFifo.sv
`include "ioSwitch_settings.svh"

module reqFifo #(
  parameter int Depth = `REQ_FIFO_DEPTH
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // write side
  input  logic                 push_i,
  input  ioSwitchPkg::ioReq_t  pushItem_i,
  output logic                 full_o,
  // read side
  input  logic                 pop_i,
  output ioSwitchPkg::ioReq_t  popItem_o,
  output logic                 empty_o
);

  import ioSwitchPkg::*;

  localparam int PtrW = $clog2(Depth);
  localparam int CntW = $clog2(Depth + 1);
  localparam logic [CntW-1:0] FullCount = CntW'(Depth);

  if (Depth < 2 || (Depth & (Depth - 1)) != 0) begin : depthCheck
    $error("reqFifo depth must be a power of two of at least 2");
  end

  ioReq_t           mem [Depth];
  logic [PtrW-1:0]  wrPtr;
  logic [PtrW-1:0]  rdPtr;
  logic [CntW-1:0]  count;
  logic             doPush;
  logic             doPop;

  assign full_o  = count == FullCount;
  assign empty_o = count == '0;

  // push is a valid level, it only lands once there is room
  assign doPush = push_i && !full_o;
  assign doPop  = pop_i && !empty_o;

  // head is read straight out of the array
  assign popItem_o = mem[rdPtr];

  always_ff @(posedge clk_i) begin
    if (doPush) begin
      mem[wrPtr] <= pushItem_i;
    end
  end

  //////////////////////////////////////////////////
  // pointers and occupancy
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      // power-of-two depth, pointers wrap on overflow
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      if (doPush && !doPop) begin
        count <= count + 1'b1;
      end else if (doPop && !doPush) begin
        count <= count - 1'b1;
      end
    end
  end

  // a push refused for lack of room is offered again
  assert property (@(posedge clk_i) disable iff (rst_i)
    push_i && full_o |=> push_i);

  // consumer never pops an empty FIFO
  assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> !empty_o);

endmodule

// File: flist.f
+incdir+design
design/ioSwitchPkg.sv
design/addrDecoder.sv
design/reqFifo.sv
design/ioDispatcher.sv
design/ioSwitch.sv
tests/ioSwitchTb.sv

// File: tests/ioSwitchTb.sv
`include "ioSwitch_settings.svh"

module ioSwitchTb;
  timeunit 1ns;
  timeprecision 100ps;

  import ioSwitchPkg::*;

  localparam int AW = `IO_ADDR_WIDTH;
  localparam int DW = `IO_DATA_WIDTH;
  localparam int SW = `IO_SOURCE_WIDTH;
  localparam int NumReq = 400;
  localparam int ClkPeriod = 4;
  localparam logic [31:0] Seed = 32'h1cbfec91;

  logic clk_i, rst_i;
  logic reqValid_i, reqReady_o, reqWrite_i;
  logic [AW-1:0] reqAddr_i;
  logic [DW-1:0] reqData_i;
  logic [SW-1:0] reqSource_i;
  logic devValid_o, devWrite_o, devReady_i, errValid_o;
  ioTarget_e devTarget_o;
  logic [AW-1:0] devOffset_o;
  logic [DW-1:0] devData_o;
  logic [SW-1:0] devSource_o, errSource_o;

  logic [31:0] lfsr = Seed;
  int readyMode, stallLeft, sent, errCount, devSeen, errSeen;
  string testName = "reset";
  ioReq_t devQ[$];
  logic [SW-1:0] errQ[$];
  ioReq_t exp, held;
  logic [SW-1:0] expSrc;
  logic holdValid;

  ioSwitch dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(NumReq * 20 * ClkPeriod);
    $display("watchdog: run timed out at %0t with %0d requests sent", $time, sent);
    $display("TEST FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // random numbers and address map
  //////////////////////////////////////////////////

  // taps 32 22 2 1
  function automatic logic lfsrStep();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] randBits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[62:0], lfsrStep()};
    return v;
  endfunction

  function automatic logic [AW-1:0] winBase(input int i);
    case (i)
      0: return AW'(`CLINT_BASE);
      1: return AW'(`PLIC_BASE);
      2: return AW'(`UART_BASE);
      3: return AW'(`SDHCI_BASE);
      default: return AW'(`DVI_BASE);
    endcase
  endfunction

  function automatic logic [AW-1:0] winMask(input int i);
    case (i)
      0: return AW'(`CLINT_MASK);
      1: return AW'(`PLIC_MASK);
      2: return AW'(`UART_MASK);
      3: return AW'(`SDHCI_MASK);
      default: return AW'(`DVI_MASK);
    endcase
  endfunction

  function automatic ioTarget_e winTarget(input int i);
    case (i)
      0: return TgtClint;
      1: return TgtPlic;
      2: return TgtUart;
      3: return TgtSdhci;
      default: return TgtDvi;
    endcase
  endfunction

  // reference decode, mask bits cleared must equal the base
  function automatic ioReq_t expectItem(input logic [AW-1:0] addr, input logic w,
                                        input logic [DW-1:0] d, input logic [SW-1:0] s);
    ioReq_t e;
    e.target = TgtError;
    e.offset = '0;
    e.write = w;
    e.data = d;
    e.source = s;
    for (int i = 0; i < 5; i++) begin
      if ((addr & ~winMask(i)) == winBase(i)) begin
        e.target = winTarget(i);
        e.offset = addr & winMask(i);
      end
    end
    return e;
  endfunction

  function automatic logic [AW-1:0] genAddr(input bit allowMiss);
    logic [2:0] sel;
    logic [5:0] high;
    sel = 3'(randBits(3));
    if (!allowMiss && sel > 3'd4) sel = sel - 3'd5;
    case (sel)
      3'd5: begin
        // low miss, far away or just past the display window
        if (randBits(1) != 0) return AW'(32'h2000_0000) | AW'(randBits(28));
        return AW'(32'h1003_0000) | AW'(randBits(16));
      end
      3'd6, 3'd7: begin
        high = 6'(randBits(6));
        if (high == 6'h0) high = 6'h20;
        return {high, 32'(randBits(32))};
      end
      default: return winBase(sel) | (AW'(randBits(32)) & winMask(sel));
    endcase
  endfunction

  function automatic ioReq_t devNow();
    ioReq_t a;
    a.target = devTarget_o;
    a.offset = devOffset_o;
    a.write = devWrite_o;
    a.data = devData_o;
    a.source = devSource_o;
    return a;
  endfunction

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  // falling edge, then devReady_i per mode
  task automatic nextCycle();
    @(negedge clk_i);
    if (readyMode == 0) begin
      devReady_i = 1'b0;
    end else if (readyMode == 1) begin
      devReady_i = 1'b1;
    end else if (stallLeft > 0) begin
      stallLeft--;
      devReady_i = 1'b0;
    end else if (randBits(5) == 0) begin
      stallLeft = int'(randBits(4));
      devReady_i = 1'b0;
    end else begin
      devReady_i = randBits(2) != 0;
    end
  endtask

  task automatic driveReq(input logic [AW-1:0] addr);
    reqAddr_i = addr;
    reqWrite_i = 1'(randBits(1));
    reqData_i = DW'(randBits(DW));
    reqSource_i = SW'(randBits(SW));
    reqValid_i = 1'b1;
    sent++;
  endtask

  task automatic sendReq(input logic [AW-1:0] addr);
    driveReq(addr);
    while (!reqReady_o) nextCycle();
    nextCycle();
    reqValid_i = 1'b0;
  endtask

  task automatic checkLatency(input logic [AW-1:0] addr, input logic isMiss);
    logic seen;
    driveReq(addr);
    assert (reqReady_o === 1'b1)
      else begin
        errCount++;
        $display("idle switch did not accept a request (%s)", testName);
      end
    for (int k = 1; k <= 3; k++) begin
      nextCycle();
      if (k == 1) reqValid_i = 1'b0;
      seen = isMiss ? errValid_o : devValid_o;
      assert (seen === (k == 3))
        else begin
          errCount++;
          $display("** Error %s: output at cycle %0d expected %0d actual %0d",
                   testName, k, k == 3, seen);
        end
    end
    repeat (2) nextCycle();
  endtask

  //////////////////////////////////////////////////
  // monitor and reference model
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (holdValid) begin
        assert (devValid_o === 1'b1 && devNow() === held)
          else begin
            errCount++;
            $display("** Error %s: stalled item expected %h actual %h", testName, held, devNow());
          end
      end
      if (reqValid_i && reqReady_o) begin
        exp = expectItem(reqAddr_i, reqWrite_i, reqData_i, reqSource_i);
        if (exp.target == TgtError) errQ.push_back(exp.source);
        else devQ.push_back(exp);
      end
      if (devValid_o && devReady_i) begin
        devSeen++;
        assert (devQ.size() != 0)
          else begin
            errCount++;
            $display("device transfer with no request pending (%s)", testName);
          end
        if (devQ.size() != 0) begin
          exp = devQ.pop_front();
          assert (devNow() === exp)
            else begin
              errCount++;
              $display("** Error %s: device item expected %h actual %h", testName, exp, devNow());
            end
        end
      end
      if (errValid_o) begin
        errSeen++;
        assert (errQ.size() != 0)
          else begin
            errCount++;
            $display("error pulse with no miss pending (%s)", testName);
          end
        if (errQ.size() != 0) begin
          expSrc = errQ.pop_front();
          assert (errSource_o === expSrc)
            else begin
              errCount++;
              $display("** Error %s: error source expected %h actual %h",
                       testName, expSrc, errSource_o);
            end
        end
      end
      holdValid = devValid_o && !devReady_i;
      held = devNow();
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    int waited;
    rst_i = 1'b1;
    reqValid_i = 1'b0;
    reqAddr_i = '0;
    reqWrite_i = 1'b0;
    reqData_i = '0;
    reqSource_i = '0;
    devReady_i = 1'b0;
    readyMode = 1;
    holdValid = 1'b0;
    repeat (3) @(negedge clk_i);
    rst_i = 1'b0;
    nextCycle();
    assert (reqReady_o === 1'b1 && devValid_o === 1'b0 && errValid_o === 1'b0)
      else begin
        errCount++;
        $display("** Error %s: ready/dev/err expected 100 actual %b%b%b",
                 testName, reqReady_o, devValid_o, errValid_o);
      end

    testName = "latency";
    checkLatency(genAddr(0), 1'b0);
    checkLatency({6'h01, 32'h1000_0000}, 1'b1);

    // device stalled, six items fill the pipeline
    testName = "stall";
    readyMode = 0;
    nextCycle();
    for (int i = 0; i < 7; i++) begin
      driveReq(genAddr(0));
      waited = 0;
      while (!reqReady_o) begin
        nextCycle();
        waited++;
        if (waited == 12) readyMode = 2;
      end
      assert ((waited > 0) == (i == 6))
        else begin
          errCount++;
          $display("** Error %s: request %0d blocked expected %0d actual %0d",
                   testName, i, i == 6, waited > 0);
        end
      nextCycle();
      reqValid_i = 1'b0;
    end

    testName = "random";
    readyMode = 2;
    while (sent < NumReq) begin
      if (randBits(2) == 0) repeat (int'(randBits(2)) + 1) nextCycle();
      sendReq(genAddr(1));
    end

    testName = "drain";
    readyMode = 1;
    for (int i = 0; i < 50 && devQ.size() + errQ.size() > 0; i++) nextCycle();
    repeat (4) nextCycle();
    assert (devQ.size() == 0 && errQ.size() == 0)
      else begin
        errCount++;
        $display("%0d device and %0d error items never arrived", devQ.size(), errQ.size());
      end
    $display("requests %0d, device transfers %0d, error pulses %0d, errors %0d",
             sent, devSeen, errSeen, errCount);
    if (errCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
